// ==== source/sort_data_pkg.sv ====
////////////////////
// Sorter data types
// Default lane count, value width and the
// vector types used for lane values and lane indices
////////////////////

`default_nettype none

package sort_data_pkg;

    // Defaults picked up by the top level
    localparam int N_ITEMS_DEF = 32;
    localparam int DATA_W_DEF  = 8;

    // Index width covers up to 64 lanes
    localparam int LANE_IDX_W = 6;

    // One lane value at the default width
    typedef logic [DATA_W_DEF-1:0] lane_val_t;

    // Network position of a lane
    typedef logic [LANE_IDX_W-1:0] lane_idx_t;

endpackage : sort_data_pkg

`default_nettype wire

// ==== source/sort_ctrl_pkg.sv ====
////////////////////
// Sorter control types
// Step counters and the sequencer phase
////////////////////

`default_nettype none

package sort_ctrl_pkg;

    // Bitonic stage, 1 up to log2 of the lane count
    typedef logic [2:0] stage_t;

    // Sub-step inside a stage, counts down to 0
    typedef logic [2:0] substep_t;

    typedef enum logic {
        PHASE_IDLE = 1'b0,
        PHASE_RUN  = 1'b1
    } sort_phase_t;

endpackage : sort_ctrl_pkg

`default_nettype wire

// ==== source/sort_step_sequencer.sv ====
////////////////////
// Bitonic step sequencer
// Walks the stage and sub-step counters after a load,
// one network step per clock, and pulses vld_out
// when the last step has been written
////////////////////

`timescale 1ns/100ps
`default_nettype none

module sort_step_sequencer #(
    parameter int N_ITEMS = 32
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    vld_in,
    output logic                    load,
    output logic                    step_en,
    output sort_ctrl_pkg::stage_t   stage,
    output sort_ctrl_pkg::substep_t substep,
    output logic                    vld_out
);
    import sort_ctrl_pkg::*;

    // Final stage of the network
    localparam stage_t LAST_STAGE = stage_t'($clog2(N_ITEMS));

    sort_phase_t phase;
    stage_t      stage_q;
    substep_t    substep_q;
    logic        last_step;
    logic        done_q;

    assign load    = vld_in;
    assign step_en = (phase == PHASE_RUN);
    assign stage   = stage_q;
    assign substep = substep_q;
    assign vld_out = done_q;

    // Step currently applied is the last of the run
    assign last_step = (stage_q == LAST_STAGE) && (substep_q == '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase     <= PHASE_IDLE;
            stage_q   <= stage_t'(1);
            substep_q <= '0;
            done_q    <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (vld_in) begin
                // New batch restarts from the first step
                phase     <= PHASE_RUN;
                stage_q   <= stage_t'(1);
                substep_q <= '0;
            end else if (phase == PHASE_RUN) begin
                if (last_step) begin
                    phase  <= PHASE_IDLE;
                    done_q <= 1'b1;
                end else if (substep_q == '0) begin
                    // Next stage starts at its widest distance
                    stage_q   <= stage_q + 1'b1;
                    substep_q <= substep_t'(stage_q);
                end else begin
                    substep_q <= substep_q - 1'b1;
                end
            end
        end
    end

endmodule : sort_step_sequencer

`default_nettype wire

// ==== source/bitonic_exchange_bank.sv ====
////////////////////
// Compare-exchange bank
// Lane registers plus N_ITEMS/2 compare-exchange
// units; partner and direction of each unit follow
// from the current stage and sub-step
////////////////////

`timescale 1ns/100ps
`default_nettype none

module bitonic_exchange_bank #(
    parameter int N_ITEMS = 32,
    parameter int DATA_W  = 8
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      load,
    input  logic [N_ITEMS*DATA_W-1:0] din,
    input  logic                      step_en,
    input  sort_ctrl_pkg::stage_t     stage,
    input  sort_ctrl_pkg::substep_t   substep,
    output logic [N_ITEMS*DATA_W-1:0] lanes
);
    import sort_data_pkg::*;
    import sort_ctrl_pkg::*;

    localparam int N_UNITS = N_ITEMS / 2;
    localparam int IDX_W   = $clog2(N_ITEMS);
    localparam int UNIT_W  = $clog2(N_UNITS);

    typedef logic [DATA_W-1:0] val_t;

    val_t      lane_q   [N_ITEMS];
    val_t      lane_nxt [N_ITEMS];
    val_t      lo_res   [N_UNITS];
    val_t      hi_res   [N_UNITS];
    lane_idx_t sub_mask;
    lane_idx_t sub_bit;

    // Bits below the pair distance, and the distance itself
    assign sub_mask = lane_idx_t'((1 << substep) - 1);
    assign sub_bit  = sub_mask + 1'b1;

    for (genvar u = 0; u < N_UNITS; u++) begin : g_unit
        lane_idx_t lo_idx;
        lane_idx_t hi_idx;
        lane_idx_t dir_bits;
        logic      ascending;
        logic      swap;
        val_t      a;
        val_t      b;

        // Lower lane is the unit number with a 0 inserted at bit substep
        assign lo_idx = ((lane_idx_t'(u) & ~sub_mask) << 1) | (lane_idx_t'(u) & sub_mask);
        assign hi_idx = lo_idx | sub_bit;

        // Bit stage of the lane picks the direction
        assign dir_bits  = lo_idx >> stage;
        assign ascending = ~dir_bits[0];

        assign a = lane_q[lo_idx[IDX_W-1:0]];
        assign b = lane_q[hi_idx[IDX_W-1:0]];

        assign swap      = ascending ? (a > b) : (a < b);
        assign lo_res[u] = swap ? b : a;
        assign hi_res[u] = swap ? a : b;
    end

    for (genvar p = 0; p < N_ITEMS; p++) begin : g_lane
        lane_idx_t unit_idx;
        logic      is_hi;

        // Unit serving this lane, bit substep removed from p
        assign unit_idx = ((lane_idx_t'(p) >> 1) & ~sub_mask) | (lane_idx_t'(p) & sub_mask);
        assign is_hi    = |(lane_idx_t'(p) & sub_bit);

        assign lane_nxt[p] = is_hi ? hi_res[unit_idx[UNIT_W-1:0]]
                                   : lo_res[unit_idx[UNIT_W-1:0]];

        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                lane_q[p] <= '0;
            end else if (load) begin
                lane_q[p] <= din[p*DATA_W +: DATA_W];
            end else if (step_en) begin
                lane_q[p] <= lane_nxt[p];
            end
        end

        assign lanes[p*DATA_W +: DATA_W] = lane_q[p];
    end

endmodule : bitonic_exchange_bank

`default_nettype wire

// ==== source/bitonic_sorter.sv ====
////////////////////
// Iterative bitonic sorter
// Loads a batch on vld_in, sorts it ascending over
// the network steps and flags the result on vld_out
////////////////////

`timescale 1ns/100ps
`default_nettype none

module bitonic_sorter #(
    parameter int N_ITEMS = sort_data_pkg::N_ITEMS_DEF,
    parameter int DATA_W  = sort_data_pkg::DATA_W_DEF
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      vld_in,
    input  logic [N_ITEMS*DATA_W-1:0] din,
    output logic                      vld_out,
    output logic [N_ITEMS*DATA_W-1:0] dout
);
    import sort_ctrl_pkg::*;

    logic     load;
    logic     step_en;
    stage_t   stage;
    substep_t substep;

    sort_step_sequencer #(
        .N_ITEMS (N_ITEMS)
    ) u_sort_step_sequencer (
        .clk     (clk),
        .rst_n   (rst_n),
        .vld_in  (vld_in),
        .load    (load),
        .step_en (step_en),
        .stage   (stage),
        .substep (substep),
        .vld_out (vld_out)
    );

    // Lane registers drive dout directly
    bitonic_exchange_bank #(
        .N_ITEMS (N_ITEMS),
        .DATA_W  (DATA_W)
    ) u_bitonic_exchange_bank (
        .clk     (clk),
        .rst_n   (rst_n),
        .load    (load),
        .din     (din),
        .step_en (step_en),
        .stage   (stage),
        .substep (substep),
        .lanes   (dout)
    );

endmodule : bitonic_sorter

`default_nettype wire

// ==== verification/sort_tb_model.svh ====
////////////////////
// Sorter reference model
// Ascending sort of a loaded batch and the
// compare helpers used by the checker
////////////////////

`ifndef SORT_TB_MODEL_SVH
`define SORT_TB_MODEL_SVH

// Insertion sort over the lanes of a packed batch
function automatic logic [BUS_W-1:0] sort_batch(input logic [BUS_W-1:0] bus);
    lane_val_t        vals [N_ITEMS];
    lane_val_t        tmp;
    logic [BUS_W-1:0] res;
    int               i;
    int               j;

    for (i = 0; i < N_ITEMS; i++) begin
        vals[i] = bus[i*DATA_W +: DATA_W];
    end
    for (i = 1; i < N_ITEMS; i++) begin
        j = i;
        while (j > 0 && vals[j-1] > vals[j]) begin
            tmp       = vals[j];
            vals[j]   = vals[j-1];
            vals[j-1] = tmp;
            j--;
        end
    end
    res = '0;
    for (i = 0; i < N_ITEMS; i++) begin
        res[i*DATA_W +: DATA_W] = vals[i];
    end
    return res;
endfunction

task automatic check_lanes(input logic [BUS_W-1:0] exp_bus, input logic [BUS_W-1:0] act_bus);
    lane_val_t exp_val;
    lane_val_t act_val;
    lane_idx_t lane;
    int        i;

    for (i = 0; i < N_ITEMS; i++) begin
        lane    = lane_idx_t'(i);
        exp_val = exp_bus[i*DATA_W +: DATA_W];
        act_val = act_bus[i*DATA_W +: DATA_W];
        assert (act_val === exp_val) else begin
            $display("ERROR t=%0t dout lane %0d expected %0d got %0d",
                     $time, lane, exp_val, act_val);
            stop_on_error();
        end
    end
endtask

task automatic check_vld(input logic exp_val, input logic act_val);
    assert (act_val === exp_val) else begin
        $display("ERROR t=%0t vld_out expected %0b got %0b", $time, exp_val, act_val);
        stop_on_error();
    end
endtask

`endif

// ==== verification/sort_tb.sv ====
////////////////////
// Bitonic sorter testbench
// Random and corner batches, reloads during a run,
// checked against a sorting model
////////////////////

`timescale 1ns/100ps
`default_nettype none

module sort_tb;
    import sort_data_pkg::*;

    localparam int N_ITEMS    = N_ITEMS_DEF;
    localparam int DATA_W     = DATA_W_DEF;
    localparam int BUS_W      = N_ITEMS * DATA_W;
    localparam int LOG_N      = $clog2(N_ITEMS);
    localparam int N_STEPS    = LOG_N * (LOG_N + 1) / 2;
    localparam int CLK_PERIOD = 8;
    localparam int N_RANDOM   = 200;
    localparam int N_ABORT    = 20;
    localparam int N_CHAIN    = 20;
    localparam int N_RUNS     = 4 + N_RANDOM + 2 * N_ABORT + 2 * N_CHAIN;
    localparam int EXP_DONE   = 4 + N_RANDOM + N_ABORT + 2 * N_CHAIN;
    localparam int WDOG_CYC   = N_RUNS * 40 + 16 + 64;

    logic             clk;
    logic             rst_n;
    logic             vld_in;
    logic [BUS_W-1:0] din;
    logic             vld_out;
    logic [BUS_W-1:0] dout;

    integer seed = 67924;

    // Checker state
    logic             load_seen = 1'b0;
    logic             pending   = 1'b0;
    logic             holding   = 1'b0;
    logic             exp_vld;
    int               edge_cnt  = 0;
    int               done_cnt  = 0;
    logic [BUS_W-1:0] next_bus;
    logic [BUS_W-1:0] exp_bus;

    task automatic stop_on_error();
        $display("Done: errors found");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    `include "sort_tb_model.svh"

    bitonic_sorter #(
        .N_ITEMS (N_ITEMS),
        .DATA_W  (DATA_W)
    ) u_bitonic_sorter (
        .clk     (clk),
        .rst_n   (rst_n),
        .vld_in  (vld_in),
        .din     (din),
        .vld_out (vld_out),
        .dout    (dout)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [BUS_W-1:0] random_batch();
        logic [BUS_W-1:0] bus;
        int               i;

        for (i = 0; i < N_ITEMS; i++) begin
            bus[i*DATA_W +: DATA_W] = lane_val_t'($random(seed));
        end
        return bus;
    endfunction

    // 0 all equal, 1 mixed 0 and 255, 2 ascending, 3 descending
    function automatic logic [BUS_W-1:0] corner_batch(input int kind);
        logic [BUS_W-1:0] bus;
        int               i;

        for (i = 0; i < N_ITEMS; i++) begin
            case (kind)
                0:       bus[i*DATA_W +: DATA_W] = lane_val_t'(8'h5A);
                1:       bus[i*DATA_W +: DATA_W] = (((i ^ (i >> 2)) & 1) != 0) ? 8'hFF : 8'h00;
                2:       bus[i*DATA_W +: DATA_W] = lane_val_t'(i * 3);
                default: bus[i*DATA_W +: DATA_W] = lane_val_t'(255 - i * 3);
            endcase
        end
        return bus;
    endfunction

    // Called right after a rising edge, returns at the load edge
    task automatic load_batch(input logic [BUS_W-1:0] batch);
        vld_in <= 1'b1;
        din    <= batch;
        @(posedge clk);
        vld_in <= 1'b0;
    endtask

    task automatic wait_done();
        do begin
            @(posedge clk);
        end while (vld_out !== 1'b1);
    endtask

    // Outputs are checked mid-cycle, away from the driving edge
    always @(negedge clk) begin
        if (rst_n) begin
            if (load_seen) begin
                exp_bus  = sort_batch(next_bus);
                pending  = 1'b1;
                holding  = 1'b0;
                edge_cnt = 0;
            end else if (pending) begin
                edge_cnt++;
            end
            exp_vld = pending && (edge_cnt == N_STEPS);
            check_vld(exp_vld, vld_out);
            // Pulses seen on the DUT output
            if (vld_out === 1'b1) begin
                done_cnt++;
            end
            if (exp_vld) begin
                pending = 1'b0;
                holding = 1'b1;
            end
            // Sorted batch must stay put until the next load
            if (holding) begin
                check_lanes(exp_bus, dout);
            end
            load_seen = vld_in;
            if (vld_in) begin
                next_bus = din;
            end
        end
    end

    initial begin
        int n;
        int k;
        int gap;

        rst_n  = 1'b0;
        vld_in = 1'b0;
        din    = '0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        // Idle stretch, no vld_out expected
        repeat (20) @(posedge clk);

        for (k = 0; k < 4; k++) begin
            load_batch(corner_batch(k));
            wait_done();
        end

        for (n = 0; n < N_RANDOM; n++) begin
            gap = $unsigned($random(seed)) % 8;
            repeat (gap) @(posedge clk);
            load_batch(random_batch());
            wait_done();
        end

        // Reload somewhere inside a run
        for (n = 0; n < N_ABORT; n++) begin
            load_batch(random_batch());
            gap = $unsigned($random(seed)) % N_STEPS;
            repeat (gap) @(posedge clk);
            load_batch(random_batch());
            wait_done();
        end

        // Next load sampled in the done cycle
        for (n = 0; n < N_CHAIN; n++) begin
            load_batch(random_batch());
            repeat (N_STEPS) @(posedge clk);
            load_batch(random_batch());
            wait_done();
        end

        repeat (8) @(posedge clk);
        assert (done_cnt == EXP_DONE) else begin
            $display("ERROR t=%0t done pulse count expected %0d got %0d",
                     $time, EXP_DONE, done_cnt);
            stop_on_error();
        end
        $display("Done: no errors");
        $finish;
    end

    initial begin
        #(WDOG_CYC * CLK_PERIOD);
        $display("Watchdog expired, the sorter did not finish all batches in time");
        stop_on_error();
    end

endmodule : sort_tb

`default_nettype wire

// ==== files.f ====
+incdir+verification
source/sort_data_pkg.sv
source/sort_ctrl_pkg.sv
source/sort_step_sequencer.sv
source/bitonic_exchange_bank.sv
source/bitonic_sorter.sv
verification/sort_tb.sv

// ==== Makefile ====
# Verilator build and run of the bitonic sorter testbench

SOURCES := $(shell grep -v '^+' files.f)
HEADERS := $(wildcard verification/*.svh)

.PHONY: all run clean

all: run

# Rebuilt only when a source, header or the file list changes
obj_dir/Vsort_tb: files.f $(SOURCES) $(HEADERS)
	verilator --binary --timing --assert -f files.f --top-module sort_tb -o Vsort_tb

run: obj_dir/Vsort_tb
	./obj_dir/Vsort_tb > sim.log 2>&1; cat sim.log
	grep -q "Done: no errors" sim.log

clean:
	rm -rf obj_dir sim.log
